/* adxl_pkg.sv */
// ----------------------------------------------------------
// ADXL355 reader shared types, widths and timing constants
// ----------------------------------------------------------

package adxl_pkg;

  // data widths
  typedef logic [7:0]  byte_t;       // spi byte, command or received data
  typedef logic [3:0]  len_t;        // transfer length incl. command byte
  typedef logic [15:0] word_t;       // two kept bytes packed
  typedef logic [8:0]  buf_addr_t;   // 512 word buffer
  typedef logic [16:0] rd_word_t;    // x tag above the packed word

  // running transaction index
  // upper nibble counts bytes, lower nibble is the half-bit phase
  typedef logic [7:0] spi_index_t;

  // reader sequencer states
  typedef enum logic [1:0]
  {
    ST_IDLE,  // waiting for sync, grant may change
    ST_RUN,   // shifting bytes
    ST_DONE   // last phase, csn goes back high
  } reader_state_t;

  // clock enable divider
  localparam int unsigned CLK_DIV     = 4;  // clocks per clk_en pulse
  localparam int unsigned CLK_DIV_W   = $clog2(CLK_DIV);

  // automatic sync rate, counted in clk_en pulses
  localparam int unsigned SYNC_PERIOD = 512;
  localparam int unsigned SYNC_CNT_W  = $clog2(SYNC_PERIOD);

  // sample buffer size in words
  localparam int unsigned BUF_DEPTH   = 512;

  // byte number of the first data byte, x axis msb
  localparam logic [3:0] XYZ_FIRST_BYTE = 4'd1;

  // fixed index points at the start of a transaction
  localparam spi_index_t IDX_CSN_FALL = 8'd1;  // chip select goes low
  localparam spi_index_t IDX_SCLK_ON  = 8'd2;  // sclk enabled, command loaded

  // phases relative to {len, phase} at the end of a transaction
  localparam logic [3:0] PH_SCLK_OFF  = 4'h2;
  localparam logic [3:0] PH_CSN_RISE  = 4'h3;
  localparam logic [3:0] PH_END       = 4'h4;  // index rests here when idle

  // host line synchronizer depth
  localparam int unsigned HOST_SYNC_STAGES = 2;

endpackage

/* adxl_spi_if.sv */
// ----------------------------------------------------------
// ADXL355 SPI line bundle between reader and pin mux
// ----------------------------------------------------------
`timescale 1ns/1ps

interface adxl_spi_if;

  logic mosi;   // command bits toward the chip
  logic sclk;   // idles low, mode 0
  logic csn;    // active low select
  logic miso;   // data back from the chip

  // reader side, owns the transaction
  modport master
  (
    output mosi, sclk, csn,
    input  miso
  );

  // side that faces the chip, returns miso
  modport sensor
  (
    input  mosi, sclk, csn,
    output miso
  );

endinterface

/* adxl_tick_gen.sv */
// ----------------------------------------------------------
// clock enable divider and periodic sync pulse generator
// ----------------------------------------------------------
`timescale 1ns/1ps

module adxl_tick_gen
(
  input  logic clk,
  input  logic arst_n,
  input  logic auto_en,    // periodic sync on
  output logic clk_en,     // one clock every CLK_DIV
  output logic sync_tick   // one clock every SYNC_PERIOD clk_en pulses
);
  import adxl_pkg::*;

  logic [CLK_DIV_W-1:0]  div_cnt;
  logic [SYNC_CNT_W-1:0] sync_cnt;

  // clock divider
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      div_cnt <= '0;
      clk_en  <= 1'b0;
    end
    else if (div_cnt == CLK_DIV_W'(CLK_DIV - 1))
    begin
      div_cnt <= '0;
      clk_en  <= 1'b1;  // single clock pulse
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      clk_en  <= 1'b0;
    end

  // sync counter, held cleared while automatic mode is off
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      sync_cnt  <= '0;
      sync_tick <= 1'b0;
    end
    else
    begin
      sync_tick <= 1'b0;
      if (!auto_en)
        sync_cnt <= '0;
      else if (clk_en)
      begin
        if (sync_cnt == SYNC_CNT_W'(SYNC_PERIOD - 1))
        begin
          sync_cnt  <= '0;
          sync_tick <= 1'b1;
        end
        else
          sync_cnt <= sync_cnt + 1'b1;
      end
    end

endmodule

/* adxl_spi_reader.sv */
// ----------------------------------------------------------
// ADXL355 SPI read sequencer with byte strobes and the
// direct access grant, switched only between transactions
// ----------------------------------------------------------
`timescale 1ns/1ps

module adxl_spi_reader
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              clk_en,
  input  logic              sync,       // host start request
  input  logic              sync_tick,  // automatic start request
  input  adxl_pkg::byte_t   cmd,        // first byte sent
  input  adxl_pkg::len_t    len,        // bytes incl. command
  input  logic              direct,     // host wants the chip
  output logic              direct_en,  // grant level for the pin mux
  output logic              busy,
  adxl_spi_if.master        spi,
  output adxl_pkg::byte_t   wrdata,
  output logic              wr,         // every data byte
  output logic              wr16,       // skips third byte of each axis
  output logic              x           // first byte of an xyz set
);
  import adxl_pkg::*;

  reader_state_t state;
  byte_t         cmd_q;
  len_t          len_q;
  spi_index_t    index;
  spi_index_t    end_index;
  logic          start;
  logic          step;        // even phase clk_en inside a transaction
  logic          csn_q, sclk_en, sclk_q;
  byte_t         mosi_sr, miso_sr;
  byte_t         bit_mark;    // walking one, msb set on the eighth bit
  logic [1:0]    axis_cnt;    // byte position inside a 3 byte axis
  logic [3:0]    byte_num;    // number of the byte just completed
  logic          byte_done, data_byte;

  assign end_index = {len_q, PH_END};
  assign start     = (sync | sync_tick) && (state == ST_IDLE) && !direct_en;
  assign step      = clk_en && !index[0] && (state != ST_IDLE);
  assign byte_num  = index[7:4] - 4'd1;
  assign byte_done = step && bit_mark[7] && sclk_en;
  assign data_byte = byte_done && (byte_num != 4'd0);  // command byte gives no strobe
  assign busy      = (state != ST_IDLE);

  // sequencer
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      state <= ST_IDLE;
      index <= {4'd0, PH_END};  // rest as finished
      cmd_q <= '0;
      len_q <= '0;
    end
    else
      case (state)
        ST_IDLE:
          if (start)
          begin
            index <= '0;
            cmd_q <= cmd;  // sampled on the accepted sync only
            len_q <= len;
            state <= ST_RUN;
          end
        ST_RUN:
          if (clk_en)
          begin
            index <= index + spi_index_t'(1);
            if (index == end_index - spi_index_t'(2))
              state <= ST_DONE;
          end
        ST_DONE:
          if (clk_en)
          begin
            index <= index + spi_index_t'(1);  // lands on end_index
            state <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase

  // chip select and clock from the index
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      csn_q   <= 1'b1;
      sclk_en <= 1'b0;
      sclk_q  <= 1'b0;
    end
    else if (clk_en)
    begin
      if (index == IDX_CSN_FALL)
        csn_q <= 1'b0;
      else if (index == {len_q, PH_CSN_RISE})
        csn_q <= 1'b1;
      if (index == IDX_SCLK_ON)
        sclk_en <= 1'b1;
      else if (index == {len_q, PH_SCLK_OFF})
        sclk_en <= 1'b0;
      sclk_q <= sclk_en & index[0];  // high on odd phase, clk_en/2
    end

  // grant moves only at the end of a transaction or while idle
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
      direct_en <= 1'b0;
    else if (clk_en && ((state == ST_DONE) || ((state == ST_IDLE) && !start)))
      direct_en <= direct;

  // command shifter, msb first, moves on falling sclk
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      mosi_sr  <= '0;
      bit_mark <= '0;
      axis_cnt <= '0;
    end
    else if (step)
    begin
      if (index == IDX_SCLK_ON)
      begin
        mosi_sr  <= cmd_q;
        bit_mark <= 8'h01;
        axis_cnt <= '0;
      end
      else
      begin
        mosi_sr  <= {mosi_sr[6:0], 1'b0};
        bit_mark <= {bit_mark[6:0], bit_mark[7]};
        if (data_byte)
          axis_cnt <= (axis_cnt == 2'd2) ? 2'd0 : axis_cnt + 2'd1;
      end
    end

  // miso sampled on the same phase, before sclk drops
  always_ff @(posedge clk)
    if (step)
    begin
      miso_sr <= {miso_sr[6:0], spi.miso};
      if (data_byte)
        wrdata <= {miso_sr[6:0], spi.miso};
    end

  // one clock strobes, aligned with wrdata
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      wr   <= 1'b0;
      wr16 <= 1'b0;
      x    <= 1'b0;
    end
    else
    begin
      wr   <= data_byte;
      wr16 <= data_byte && (axis_cnt != 2'd2);  // drop low bits of the 20 bit sample
      x    <= data_byte && (byte_num == XYZ_FIRST_BYTE);
    end

  assign spi.mosi = mosi_sr[7];
  assign spi.sclk = sclk_q;
  assign spi.csn  = csn_q;

endmodule

/* adxl_direct_bridge.sv */
// ----------------------------------------------------------
// host SPI synchronizer and pin mux toward the ADXL355
// ----------------------------------------------------------
`timescale 1ns/1ps

module adxl_direct_bridge
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       direct_en,  // host owns the chip pins
  adxl_spi_if.sensor reader,
  input  logic       host_sclk,
  input  logic       host_mosi,
  input  logic       host_csn,
  output logic       host_miso,
  output logic       adxl_sclk,
  output logic       adxl_mosi,
  output logic       adxl_csn,
  input  logic       adxl_miso
);
  import adxl_pkg::*;

  logic [HOST_SYNC_STAGES-1:0] sclk_sync, mosi_sync, csn_sync;

  // host lines are asynchronous to clk
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      csn_sync  <= '1;  // deselected
    end
    else
    begin
      sclk_sync <= {sclk_sync[HOST_SYNC_STAGES-2:0], host_sclk};
      mosi_sync <= {mosi_sync[HOST_SYNC_STAGES-2:0], host_mosi};
      csn_sync  <= {csn_sync[HOST_SYNC_STAGES-2:0], host_csn};
    end

  // pin mux
  assign adxl_sclk = direct_en ? sclk_sync[HOST_SYNC_STAGES-1] : reader.sclk;
  assign adxl_mosi = direct_en ? mosi_sync[HOST_SYNC_STAGES-1] : reader.mosi;
  assign adxl_csn  = direct_en ? csn_sync[HOST_SYNC_STAGES-1]  : reader.csn;

  // miso goes back to both sides unmuxed
  assign reader.miso = adxl_miso;
  assign host_miso   = adxl_miso;

endmodule

/* adxl_sample_buffer.sv */
// ----------------------------------------------------------
// ADXL355 sample buffer, packs kept bytes into 16 bit words
// with an x tag and stores them in a dual port block RAM
// ----------------------------------------------------------
`timescale 1ns/1ps

module adxl_sample_buffer
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  adxl_pkg::byte_t      wrdata,   // byte from the reader
  input  logic                 wr16,     // byte is kept
  input  logic                 x,        // first byte of an xyz set
  output adxl_pkg::buf_addr_t  wr_ptr,   // next word to write
  input  adxl_pkg::buf_addr_t  rd_addr,  // host read port
  output adxl_pkg::rd_word_t   rd_data
);
  import adxl_pkg::*;

  logic     low_half;   // next kept byte completes a word
  logic     take_high;  // byte opens a new word
  logic     take_low;   // byte closes the word
  byte_t    hi_byte;    // first byte of the pair
  logic     hi_tag;     // x seen with the first byte
  word_t    word_q;     // completed word waiting for the RAM
  logic     tag_q;
  logic     we_q;       // RAM write, one clock after the closing byte

  rd_word_t mem [BUF_DEPTH];

  // x restarts pairing so words stay aligned to each xyz set
  assign take_high = wr16 && (x || !low_half);
  assign take_low  = wr16 && low_half && !x;

  // pair toggle and write enable
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      low_half <= 1'b0;
      we_q     <= 1'b0;
    end
    else
    begin
      we_q <= take_low;
      if (take_high)
        low_half <= 1'b1;
      else if (take_low)
        low_half <= 1'b0;
    end

  // pair data
  always_ff @(posedge clk)
  begin
    if (take_high)
    begin
      hi_byte <= wrdata;  // msb byte of the axis first
      hi_tag  <= x;
    end
    if (take_low)
    begin
      word_q <= {hi_byte, wrdata};
      tag_q  <= hi_tag;
    end
  end

  // write pointer wraps at the end of the buffer
  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
      wr_ptr <= '0;
    else if (we_q)
    begin
      if (wr_ptr == buf_addr_t'(BUF_DEPTH - 1))
        wr_ptr <= '0;
      else
        wr_ptr <= wr_ptr + 1'b1;
    end

  // block RAM, write side from the packer
  always_ff @(posedge clk)
    if (we_q)
      mem[wr_ptr] <= {tag_q, word_q};

  // host side, registered read, one clock latency
  always_ff @(posedge clk)
    rd_data <= mem[rd_addr];

endmodule

/* adxl_reader_top.sv */
// ----------------------------------------------------------
// ADXL355 reader subsystem top, tick generator, reader,
// direct access bridge and sample buffer
// ----------------------------------------------------------
`timescale 1ns/1ps

module adxl_reader_top
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 auto_en,    // periodic reads
  input  logic                 sync,       // single read request
  input  adxl_pkg::byte_t      cmd,
  input  adxl_pkg::len_t       len,
  input  logic                 direct,     // host asks for the chip
  output logic                 direct_en,
  output logic                 busy,
  input  logic                 host_sclk,
  input  logic                 host_mosi,
  input  logic                 host_csn,
  output logic                 host_miso,
  output logic                 adxl_sclk,
  output logic                 adxl_mosi,
  output logic                 adxl_csn,
  input  logic                 adxl_miso,
  output logic                 byte_wr,    // per byte strobe for monitoring
  output adxl_pkg::buf_addr_t  wr_ptr,
  input  adxl_pkg::buf_addr_t  rd_addr,
  output adxl_pkg::rd_word_t   rd_data
);
  import adxl_pkg::*;

  logic  clk_en;
  logic  sync_tick;
  byte_t wrdata;
  logic  wr16;
  logic  x_tag;

  adxl_spi_if spi_bus ();  // reader to pin mux

  adxl_tick_gen u_tick_gen
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .auto_en   (auto_en),
    .clk_en    (clk_en),
    .sync_tick (sync_tick)
  );

  adxl_spi_reader u_reader
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .clk_en    (clk_en),
    .sync      (sync),
    .sync_tick (sync_tick),  // merged with sync inside
    .cmd       (cmd),
    .len       (len),
    .direct    (direct),
    .direct_en (direct_en),
    .busy      (busy),
    .spi       (spi_bus.master),
    .wrdata    (wrdata),
    .wr        (byte_wr),
    .wr16      (wr16),
    .x         (x_tag)
  );

  adxl_direct_bridge u_bridge
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .direct_en (direct_en),
    .reader    (spi_bus.sensor),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_csn  (host_csn),
    .host_miso (host_miso),
    .adxl_sclk (adxl_sclk),
    .adxl_mosi (adxl_mosi),
    .adxl_csn  (adxl_csn),
    .adxl_miso (adxl_miso)
  );

  adxl_sample_buffer u_buffer
  (
    .clk     (clk),
    .arst_n  (arst_n),
    .wrdata  (wrdata),
    .wr16    (wr16),
    .x       (x_tag),
    .wr_ptr  (wr_ptr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* tb_adxl_model.sv */
// ----------------------------------------------------------
// behavioral ADXL355 SPI slave, mode 0, logs the command
// and returns 0xA0+k for data byte k
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_adxl_model
(
  input  logic            csn,
  input  logic            sclk,
  input  logic            mosi,
  output logic            miso,
  output adxl_pkg::byte_t cmd_log,   // command of the latest frame
  output logic [7:0]      rise_cnt   // rising sclk edges since csn fell
);
  import adxl_pkg::*;

  byte_t       cmd_sr;    // command bits as they arrive
  int unsigned bit_cnt;   // bits put out since csn fell
  logic        csn_d;     // previous line levels for edge detect
  logic        sclk_d;

  // bit n of the outgoing stream, byte 0 sits under the command
  function automatic logic stream_bit(input int unsigned n);
    byte_t b;
    if (n / 8 == 0)
      b = 8'h00;
    else
      b = byte_t'(8'hA0 + n / 8);
    return b[7 - (n % 8)];  // msb first
  endfunction

  // one process owns every model variable
  initial
  begin
    miso     = 1'b0;
    cmd_log  = '0;
    rise_cnt = '0;
    cmd_sr   = '0;
    bit_cnt  = 0;
    csn_d    = 1'b1;
    sclk_d   = 1'b0;
    forever
    begin
      @(csn or sclk);
      if (csn_d && !csn)
      begin
        // frame start, first bit valid before the first rising edge
        bit_cnt  = 0;
        rise_cnt = '0;
        miso    <= stream_bit(0);
      end
      else if (!csn && sclk_d && !sclk)
      begin
        bit_cnt = bit_cnt + 1;
        miso   <= stream_bit(bit_cnt);  // shift out on falling sclk
      end
      else if (!csn && !sclk_d && sclk)
      begin
        if (rise_cnt < 8)
          cmd_sr = {cmd_sr[6:0], mosi};  // sample on rising sclk
        rise_cnt = rise_cnt + 1'b1;
        if (rise_cnt == 8'd8)
          cmd_log = cmd_sr;
      end
      csn_d  = csn;
      sclk_d = sclk;
    end
  end

endmodule

/* tb_adxl_reader.sv */
// ----------------------------------------------------------
// testbench for the ADXL355 reader subsystem, table driven
// reads, direct access and automatic mode
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_adxl_reader;
  import adxl_pkg::*;

  localparam int unsigned NUM_TESTS      = 6;
  localparam int unsigned MAX_TRANS_CLKS = (15 * 16 + 4) * CLK_DIV;
  localparam int unsigned WATCHDOG_NS    = NUM_TESTS * MAX_TRANS_CLKS * 20 * 4;

  logic      clk = 1'b0;
  logic      arst_n, auto_en, sync, direct;
  byte_t     cmd;
  len_t      len;
  logic      direct_en, busy, byte_wr;
  logic      host_sclk, host_mosi, host_csn, host_miso;
  logic      adxl_sclk, adxl_mosi, adxl_csn, adxl_miso;
  buf_addr_t wr_ptr, rd_addr;
  rd_word_t  rd_data;
  byte_t     model_cmd;
  logic [7:0] model_rises;

  // stimulus table
  string tname [NUM_TESTS];
  len_t  tlen  [NUM_TESTS];
  byte_t tcmd  [NUM_TESTS];
  byte_t texp  [NUM_TESTS];   // command the sensor must see

  rd_word_t    exp_words [16];  // predicted buffer words
  int unsigned exp_count;
  int unsigned csn_low_clks = 0;  // free running monitors
  int unsigned byte_wr_cnt  = 0;
  int unsigned low0, wr0;
  buf_addr_t   ptr0;
  string       cur_test;
  int unsigned test_errors, errors, tests_run, tests_failed;

  always #10 clk = ~clk;  // 20 ns

  adxl_reader_top dut
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .auto_en   (auto_en),
    .sync      (sync),
    .cmd       (cmd),
    .len       (len),
    .direct    (direct),
    .direct_en (direct_en),
    .busy      (busy),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_csn  (host_csn),
    .host_miso (host_miso),
    .adxl_sclk (adxl_sclk),
    .adxl_mosi (adxl_mosi),
    .adxl_csn  (adxl_csn),
    .adxl_miso (adxl_miso),
    .byte_wr   (byte_wr),
    .wr_ptr    (wr_ptr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  tb_adxl_model u_model
  (
    .csn      (adxl_csn),
    .sclk     (adxl_sclk),
    .mosi     (adxl_mosi),
    .miso     (adxl_miso),
    .cmd_log  (model_cmd),
    .rise_cnt (model_rises)
  );

  always @(posedge clk)
  begin
    if (!adxl_csn)
      csn_low_clks <= csn_low_clks + 1;  // chip select low time
    if (byte_wr)
      byte_wr_cnt <= byte_wr_cnt + 1;
  end

  task automatic compare_value(input string what, input int unsigned exp,
                               input int unsigned act);
    assert (exp == act)
    else
    begin
      $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("ERROR in %s: %s", cur_test, what);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test;
    tests_run++;
    errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    $display("test %-12s : %s (%0d errors)", cur_test, (test_errors == 0) ? "ok" : "bad",
             test_errors);
  endtask

  task automatic wait_busy(input logic level, input int unsigned max_clks);
    int unsigned n;
    n = 0;
    while ((busy !== level) && (n < max_clks))
    begin
      @(negedge clk);
      n++;
    end
    expect_true(busy === level, $sformatf("busy did not go %0b within %0d clocks",
                                          level, max_clks));
  endtask

  task automatic wait_grant(input logic level, input int unsigned max_clks);
    int unsigned n;
    n = 0;
    while ((direct_en !== level) && (n < max_clks))
    begin
      @(negedge clk);
      n++;
    end
    expect_true(direct_en === level, $sformatf("direct_en did not go %0b within %0d clocks",
                                               level, max_clks));
  endtask

  task automatic pulse_sync(input byte_t c, input len_t l);
    @(posedge clk);
    cmd  <= c;
    len  <= l;
    sync <= 1'b1;
    @(posedge clk);
    sync <= 1'b0;
  endtask

  task automatic capture_marks;
    low0 = csn_low_clks;
    wr0  = byte_wr_cnt;
    ptr0 = wr_ptr;
  endtask

  // data bytes 1..l-1, every third one dropped, rest paired in order
  task automatic predict_words(input len_t l);
    byte_t       kept [16];
    int unsigned nk;
    nk = 0;
    for (int k = 1; k < l; k++)
      if (k % 3 != 0)
      begin
        kept[nk] = byte_t'(8'hA0 + k);
        nk++;
      end
    exp_count = nk / 2;  // odd byte left over stays unwritten
    for (int w = 0; w < exp_count; w++)
      exp_words[w] = {(w == 0), kept[2 * w], kept[2 * w + 1]};  // tag on the first
  endtask

  task automatic read_word(input buf_addr_t addr, output rd_word_t val);
    @(posedge clk);
    rd_addr <= addr;
    @(posedge clk);  // one clock latency
    @(negedge clk);
    val = rd_data;
  endtask

  task automatic check_transaction(input byte_t exp_cmd, input len_t l);
    rd_word_t got;
    predict_words(l);
    compare_value("logged command", exp_cmd, model_cmd);
    compare_value("sclk rising edges", l * 8, model_rises);
    compare_value("csn low clocks", (l * 16 + 2) * CLK_DIV, csn_low_clks - low0);
    compare_value("byte strobes", l - 1, byte_wr_cnt - wr0);
    compare_value("wr_ptr", (ptr0 + exp_count) % BUF_DEPTH, wr_ptr);
    for (int w = 0; w < exp_count; w++)
    begin
      read_word(buf_addr_t'((ptr0 + w) % BUF_DEPTH), got);
      compare_value($sformatf("data word %0d", w), exp_words[w][15:0], got[15:0]);
      compare_value($sformatf("x tag word %0d", w), exp_words[w][16], got[16]);
    end
  endtask

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    int unsigned seed_val;
    int unsigned n, early, busy_seen;
    buf_addr_t   ptr1;
    byte_t       dcmd, acmd;
    logic [2:0]  pat, prev;  // {csn, sclk, mosi}
    arst_n    = 1'b0;
    auto_en   = 1'b0;
    sync      = 1'b0;
    cmd       = '0;
    len       = '0;
    direct    = 1'b0;
    host_sclk = 1'b0;
    host_mosi = 1'b0;
    host_csn  = 1'b1;
    rd_addr   = '0;
    errors    = 0;
    tests_run = 0;
    tests_failed = 0;
    seed_val  = $urandom(32'h30429eaa);
    tlen = '{4'd15, 4'd2, 4'd7, 4'd10, 4'd4, 4'd13};
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      tname[i] = $sformatf("read_len%0d", tlen[i]);
      tcmd[i]  = byte_t'($urandom);
      texp[i]  = tcmd[i];
    end

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    start_test("reset");
    @(negedge clk);
    compare_value("adxl_csn", 1, adxl_csn);
    compare_value("adxl_sclk", 0, adxl_sclk);
    compare_value("adxl_mosi", 0, adxl_mosi);
    compare_value("busy", 0, busy);
    compare_value("direct_en", 0, direct_en);
    compare_value("byte_wr", 0, byte_wr);
    compare_value("wr_ptr", 0, wr_ptr);
    finish_test();

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      start_test(tname[i]);
      capture_marks();
      pulse_sync(tcmd[i], tlen[i]);
      wait_busy(1'b1, 16);
      wait_busy(1'b0, MAX_TRANS_CLKS + 16);
      repeat (4) @(negedge clk);
      check_transaction(texp[i], tlen[i]);
      finish_test();
    end

    // grant requested mid transaction, must wait for the end
    start_test("direct");
    dcmd = byte_t'($urandom);
    capture_marks();
    pulse_sync(dcmd, 4'd6);
    wait_busy(1'b1, 16);
    @(posedge clk);
    direct <= 1'b1;
    n     = 0;
    early = 0;
    while ((busy === 1'b1) && (n < MAX_TRANS_CLKS))
    begin
      @(negedge clk);
      if ((busy === 1'b1) && (direct_en === 1'b1))
        early++;
      n++;
    end
    compare_value("clocks granted while busy", 0, early);
    wait_grant(1'b1, 4 * CLK_DIV);
    repeat (4) @(negedge clk);
    check_transaction(dcmd, 4'd6);
    ptr1      = wr_ptr;
    busy_seen = 0;
    pulse_sync(dcmd, 4'd6);  // ignored while granted
    repeat (20 * CLK_DIV)
    begin
      @(negedge clk);
      if (busy === 1'b1)
        busy_seen++;
    end
    compare_value("busy clocks while granted", 0, busy_seen);
    compare_value("wr_ptr while granted", ptr1, wr_ptr);
    prev = 3'b100;  // host lines idle
    for (int p = 0; p < 8; p++)
    begin
      pat = 3'(p);
      @(posedge clk);
      {host_csn, host_sclk, host_mosi} <= pat;
      @(posedge clk);
      @(negedge clk);
      compare_value("pins one clock after host", prev, {adxl_csn, adxl_sclk, adxl_mosi});
      compare_value("host_miso with old pins", adxl_miso, host_miso);
      @(posedge clk);
      @(negedge clk);
      compare_value("pins two clocks after host", pat, {adxl_csn, adxl_sclk, adxl_mosi});
      compare_value("host_miso", adxl_miso, host_miso);
      prev = pat;
    end
    @(posedge clk);
    {host_csn, host_sclk, host_mosi} <= 3'b100;
    direct <= 1'b0;
    wait_grant(1'b0, 4 * CLK_DIV + 4);
    finish_test();

    // periodic reads without an external sync
    start_test("auto");
    acmd = byte_t'($urandom);
    capture_marks();
    @(posedge clk);
    cmd     <= acmd;
    len     <= 4'd12;
    auto_en <= 1'b1;
    for (int t = 0; t < 2; t++)
    begin
      wait_busy(1'b1, (SYNC_PERIOD + 2) * CLK_DIV + 16);
      wait_busy(1'b0, MAX_TRANS_CLKS + 16);
      repeat (4) @(negedge clk);
      check_transaction(acmd, 4'd12);
      capture_marks();
    end
    @(posedge clk);
    auto_en <= 1'b0;
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0))
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* build.f */
adxl_pkg.sv
adxl_spi_if.sv
adxl_tick_gen.sv
adxl_spi_reader.sv
adxl_direct_bridge.sv
adxl_sample_buffer.sv
adxl_reader_top.sv
tb_adxl_model.sv
tb_adxl_reader.sv
